//--- source/mtPkg.sv
// Shared constants, field positions and word types of the TM03/TU77 drive registers
package mtPkg;

   //////////////////////////////
   // Widths
   //////////////////////////////

   localparam int wordWidth   = 16;
   localparam int regSelWidth = 5;
   localparam int unitWidth   = 3;

   // Register addresses on the Massbus register select
   localparam logic [regSelWidth-1:0] regCs1 = 5'd0;
   localparam logic [regSelWidth-1:0] regDs  = 5'd1;
   localparam logic [regSelWidth-1:0] regEr  = 5'd2;
   localparam logic [regSelWidth-1:0] regMr  = 5'd3;
   localparam logic [regSelWidth-1:0] regAs  = 5'd4;
   localparam logic [regSelWidth-1:0] regFc  = 5'd5;
   localparam logic [regSelWidth-1:0] regDt  = 5'd6;
   localparam logic [regSelWidth-1:0] regCc  = 5'd7;
   localparam logic [regSelWidth-1:0] regSn  = 5'd8;
   localparam logic [regSelWidth-1:0] regTc  = 5'd9;

   //////////////////////////////
   // CS1 function codes
   //////////////////////////////

   localparam logic [4:0] funNop        = 5'd0;
   localparam logic [4:0] funUnload     = 5'd1;
   localparam logic [4:0] funRewind     = 5'd3;
   localparam logic [4:0] funDrvClr     = 5'd4;
   localparam logic [4:0] funPreset     = 5'd8;
   localparam logic [4:0] funErase      = 5'd10;
   localparam logic [4:0] funWrTapeMark = 5'd11;
   localparam logic [4:0] funSpcFwd     = 5'd12;
   localparam logic [4:0] funSpcRev     = 5'd13;
   localparam logic [4:0] funWrChkFwd   = 5'd20;
   localparam logic [4:0] funWrChkRev   = 5'd23;
   localparam logic [4:0] funWrFwd      = 5'd24;
   localparam logic [4:0] funRdFwd      = 5'd28;
   localparam logic [4:0] funRdRev      = 5'd31;

   // Bit positions
   localparam int cs1Dry  = 7;
   localparam int dsAta   = 15;
   localparam int dsErr   = 14;
   localparam int dsMol   = 12;
   localparam int dsWrl   = 11;
   localparam int dsDpr   = 8;
   localparam int dsDry   = 7;
   localparam int erIlf   = 0;
   localparam int erPar   = 3;
   localparam int tcFcs   = 12;
   localparam int mrMaint = 0;
   localparam int mrOpLsb = 1;
   localparam int mrOpMsb = 4;

   // Maintenance op requesting even parity
   localparam logic [3:0] mrOpEvenPar = 4'd1;

   // Read-only identity words
   localparam logic [wordWidth-1:0] drvType   = 16'o142054;
   localparam logic [wordWidth-1:0] drvSerial = 16'h0001;

   //////////////////////////////
   // Written word views
   //////////////////////////////

   typedef struct packed {
      logic [wordWidth-7:0] rsvd;
      logic [4:0]           fun;
      logic                 go;
   } mtCs1View;

   // One attention bit per drive
   typedef struct packed {
      logic [wordWidth-9:0] rsvd;
      logic [7:0]           ata;
   } mtAttnView;

   typedef union packed {
      mtCs1View               ctl;
      mtAttnView              attn;
      logic [wordWidth-1:0]   raw;
   } mtWord;

endpackage

//--- source/mtIf.sv
// Interfaces carrying the decoded bus strobes and the command pulses of the drive

interface mtBusIf;
   import mtPkg::*;

   // Write strobes, one cycle each
   logic                   wrCs1;
   logic                   wrFc;
   logic                   wrMr;
   logic                   wrTc;
   logic                   wrAs;

   // Read strobe and its register select
   logic                   rd;
   logic [regSelWidth-1:0] rdSel;

   // Written word and side signals
   mtWord                  wrData;
   logic                   parErr;
   logic                   initReg;

   modport decoder (output wrCs1, wrFc, wrMr, wrTc, wrAs, rd, rdSel, wrData, parErr, initReg);
   modport cmd     (input wrCs1, wrAs, wrData, parErr);
   modport regs    (input wrCs1, wrFc, wrMr, wrTc, wrData, parErr, initReg);
   modport reader  (input rd, rdSel);
endinterface

interface mtCmdIf;
   // Decoded command pulses
   logic go;
   logic illegalFun;
   logic drvClr;
   logic preset;
   logic clrAttn;
   logic setAttn;

   modport source (output go, illegalFun, drvClr, preset, clrAttn, setAttn);
   modport sink   (input go, illegalFun, drvClr, preset, clrAttn, setAttn);
endinterface

//--- source/mtBusDecoder.sv
// Bus decoder that selects unit 0 and registers the decoded write and read strobes
module mtBusDecoder (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          init,
   input  logic [mtPkg::unitWidth-1:0]   unit,
   input  logic                          parityTest,
   input  logic                          write,
   input  logic                          read,
   input  logic [mtPkg::regSelWidth-1:0] regSel,
   input  logic [mtPkg::wordWidth-1:0]   dataIn,
   mtBusIf.decoder                       bus
);
   import mtPkg::*;

   logic select;
   logic wrSel;
   logic parReg;

   // Only drive 0 exists
   assign select = (unit == '0);
   assign wrSel  = write & select;

   // Registers covered by the parity test
   assign parReg = (regSel == regFc) | (regSel == regCc) |
                   (regSel == regMr) | (regSel == regTc);

   //////////////////////////////
   // Strobe pipeline stage
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         bus.wrCs1   <= 1'b0;
         bus.wrFc    <= 1'b0;
         bus.wrMr    <= 1'b0;
         bus.wrTc    <= 1'b0;
         bus.wrAs    <= 1'b0;
         bus.rd      <= 1'b0;
         bus.parErr  <= 1'b0;
         bus.initReg <= 1'b0;
      end else begin
         // Bad parity on CS1 drops the whole command
         bus.wrCs1   <= wrSel & (regSel == regCs1) & ~parityTest;
         bus.wrFc    <= wrSel & (regSel == regFc);
         bus.wrMr    <= wrSel & (regSel == regMr);
         bus.wrTc    <= wrSel & (regSel == regTc);
         bus.wrAs    <= wrSel & (regSel == regAs);
         bus.rd      <= read & select;
         // Write still lands, error is flagged
         bus.parErr  <= wrSel & parReg & parityTest;
         bus.initReg <= init;
      end
   end

   // Payload travels alongside the strobes
   always_ff @(posedge clk) begin
      bus.rdSel  <= regSel;
      bus.wrData <= dataIn;
   end

endmodule

//--- source/mtCommandDecoder.sv
// Command decoder for CS1 GO writes and attention summary writes
module mtCommandDecoder (
   mtBusIf.cmd    bus,
   input  logic   errActive,
   mtCmdIf.source cmd
);
   import mtPkg::*;

   logic       go;
   logic [4:0] fun;
   logic       legalFun;
   logic       attnFun;

   // GO bit of a good CS1 write
   assign go  = bus.wrCs1 & bus.wrData.ctl.go;
   assign fun = bus.wrData.ctl.fun;

   //////////////////////////////
   // Function table
   //////////////////////////////

   always_comb begin
      legalFun = 1'b0;
      attnFun  = 1'b0;
      case (fun)
         // Accepted with no tape motion behind them
         funNop, funDrvClr, funPreset,
         funWrChkFwd, funWrChkRev, funWrFwd, funRdFwd, funRdRev: begin
            legalFun = 1'b1;
         end
         // Positioning commands end with attention
         funUnload, funRewind, funErase, funWrTapeMark, funSpcFwd, funSpcRev: begin
            legalFun = 1'b1;
            attnFun  = 1'b1;
         end
         default: begin
            legalFun = 1'b0;
         end
      endcase
   end

   assign cmd.go         = go;
   assign cmd.illegalFun = go & ~legalFun;
   assign cmd.drvClr     = go & (fun == funDrvClr);
   assign cmd.preset     = go & (fun == funPreset);
   assign cmd.setAttn    = go & attnFun;

   // Clean GO or AS write for drive 0
   assign cmd.clrAttn = (go & ~errActive) | (bus.wrAs & bus.wrData.attn.ata[0]);

endmodule

//--- source/mtControlRegs.sv
// Writable drive registers CS1, FC, MR and TC with the parity inversion request
module mtControlRegs (
   input  logic                        clk,
   input  logic                        rst,
   mtBusIf.regs                        bus,
   mtCmdIf.sink                        cmd,
   output logic [mtPkg::wordWidth-1:0] cs1,
   output logic [mtPkg::wordWidth-1:0] fc,
   output logic [mtPkg::wordWidth-1:0] mr,
   output logic [mtPkg::wordWidth-1:0] tc,
   output logic                        invertParity
);
   import mtPkg::*;

   logic [4:0] cs1Fun;

   //////////////////////////////
   // CS1
   //////////////////////////////

   // Only the function field is kept
   always_ff @(posedge clk) begin
      if (rst) begin
         cs1Fun <= '0;
      end else if (bus.wrCs1) begin
         cs1Fun <= bus.wrData.ctl.fun;
      end
   end

   // GO never reads back, drive always ready
   always_comb begin
      cs1         = '0;
      cs1[5:1]    = cs1Fun;
      cs1[cs1Dry] = 1'b1;
   end

   // Frame count and maintenance
   always_ff @(posedge clk) begin
      if (rst) begin
         fc <= '0;
         mr <= '0;
      end else begin
         if (bus.wrFc) begin
            fc <= bus.wrData.raw;
         end
         if (bus.wrMr) begin
            mr <= bus.wrData.raw;
         end
      end
   end

   //////////////////////////////
   // Tape control
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst || bus.initReg || cmd.preset) begin
         tc <= '0;
      end else if (bus.wrTc) begin
         tc <= bus.wrData.raw;
      end else if (bus.wrFc) begin
         // Frame count loaded
         tc[tcFcs] <= 1'b1;
      end
   end

   // Maintenance mode with even parity op
   assign invertParity = mr[mrMaint] & (mr[mrOpMsb:mrOpLsb] == mrOpEvenPar);

endmodule

//--- source/mtStatusRegs.sv
// Error register and drive status with the attention flag
module mtStatusRegs (
   input  logic                        clk,
   input  logic                        rst,
   mtBusIf.regs                        bus,
   mtCmdIf.sink                        cmd,
   input  logic                        mediaOnline,
   input  logic                        writeLock,
   input  logic                        drivePresent,
   output logic [mtPkg::wordWidth-1:0] er,
   output logic [mtPkg::wordWidth-1:0] ds,
   output logic                        errActive
);
   import mtPkg::*;

   logic [wordWidth-1:0] erSet;
   logic                 newErr;
   logic                 ata;
   logic                 driveClear;

   // Error sources this cycle
   always_comb begin
      erSet        = '0;
      erSet[erIlf] = cmd.illegalFun;
      erSet[erPar] = bus.parErr;
   end

   assign newErr     = |erSet;
   assign driveClear = bus.initReg | cmd.drvClr;

   //////////////////////////////
   // Error register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst || driveClear) begin
         er <= '0;
      end else begin
         er <= er | erSet;
      end
   end

   assign errActive = |er;

   // Attention flag in priority order
   always_ff @(posedge clk) begin
      if (rst || driveClear) begin
         ata <= 1'b0;
      end else if (cmd.setAttn || newErr || (cmd.go && errActive)) begin
         // GO with an error pending raises attention again
         ata <= 1'b1;
      end else if (cmd.clrAttn) begin
         ata <= 1'b0;
      end
   end

   //////////////////////////////
   // Drive status word
   //////////////////////////////

   always_comb begin
      ds        = '0;
      ds[dsAta] = ata;
      ds[dsErr] = errActive;
      ds[dsMol] = mediaOnline;
      ds[dsWrl] = writeLock;
      ds[dsDpr] = drivePresent;
      // No tape motion so always ready
      ds[dsDry] = 1'b1;
   end

endmodule

//--- source/mtReadPort.sv
// Read port with the registered register multiplexer and the attention output
module mtReadPort (
   input  logic                        clk,
   input  logic                        rst,
   mtBusIf.reader                      bus,
   input  logic [mtPkg::wordWidth-1:0] cs1,
   input  logic [mtPkg::wordWidth-1:0] fc,
   input  logic [mtPkg::wordWidth-1:0] mr,
   input  logic [mtPkg::wordWidth-1:0] tc,
   input  logic [mtPkg::wordWidth-1:0] er,
   input  logic [mtPkg::wordWidth-1:0] ds,
   output logic [mtPkg::wordWidth-1:0] dataOut,
   output logic                        dataValid,
   output logic                        attention
);
   import mtPkg::*;

   logic [wordWidth-1:0] rdWord;

   //////////////////////////////
   // Register select
   //////////////////////////////

   always_comb begin
      case (bus.rdSel)
         regCs1:  rdWord = cs1;
         regDs:   rdWord = ds;
         regEr:   rdWord = er;
         regMr:   rdWord = mr;
         // Summary holds drive 0 only
         regAs:   rdWord = {{(wordWidth-1){1'b0}}, ds[dsAta]};
         regFc:   rdWord = fc;
         regDt:   rdWord = drvType;
         regSn:   rdWord = drvSerial;
         regTc:   rdWord = tc;
         // CC and unused slots
         default: rdWord = '0;
      endcase
   end

   // Capture on the read strobe
   always_ff @(posedge clk) begin
      if (bus.rd) begin
         dataOut <= rdWord;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         dataValid <= 1'b0;
      end else begin
         dataValid <= bus.rd;
      end
   end

   assign attention = ds[dsAta];

endmodule

//--- source/mtDrive.sv
// Top level of the TM03/TU77 drive 0 register set on a plain strobe bus
module mtDrive (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          init,
   input  logic [mtPkg::unitWidth-1:0]   unit,
   input  logic                          parityTest,
   input  logic                          write,
   input  logic                          read,
   input  logic [mtPkg::regSelWidth-1:0] regSel,
   input  logic [mtPkg::wordWidth-1:0]   dataIn,
   input  logic                          mediaOnline,
   input  logic                          writeLock,
   input  logic                          drivePresent,
   output logic [mtPkg::wordWidth-1:0]   dataOut,
   output logic                          dataValid,
   output logic                          attention,
   output logic                          invertParity
);
   import mtPkg::*;

   logic [wordWidth-1:0] cs1;
   logic [wordWidth-1:0] fc;
   logic [wordWidth-1:0] mr;
   logic [wordWidth-1:0] tc;
   logic [wordWidth-1:0] er;
   logic [wordWidth-1:0] ds;
   logic                 errActive;

   mtBusIf busIf ();
   mtCmdIf cmdIf ();

   //////////////////////////////
   // Input side
   //////////////////////////////

   mtBusDecoder busDecoder_i (
      .clk        (clk),
      .rst        (rst),
      .init       (init),
      .unit       (unit),
      .parityTest (parityTest),
      .write      (write),
      .read       (read),
      .regSel     (regSel),
      .dataIn     (dataIn),
      .bus        (busIf.decoder)
   );

   mtCommandDecoder commandDecoder_i (
      .bus       (busIf.cmd),
      .errActive (errActive),
      .cmd       (cmdIf.source)
   );

   // Register file
   mtControlRegs controlRegs_i (
      .clk          (clk),
      .rst          (rst),
      .bus          (busIf.regs),
      .cmd          (cmdIf.sink),
      .cs1          (cs1),
      .fc           (fc),
      .mr           (mr),
      .tc           (tc),
      .invertParity (invertParity)
   );

   mtStatusRegs statusRegs_i (
      .clk          (clk),
      .rst          (rst),
      .bus          (busIf.regs),
      .cmd          (cmdIf.sink),
      .mediaOnline  (mediaOnline),
      .writeLock    (writeLock),
      .drivePresent (drivePresent),
      .er           (er),
      .ds           (ds),
      .errActive    (errActive)
   );

   // Output side
   mtReadPort readPort_i (
      .clk       (clk),
      .rst       (rst),
      .bus       (busIf.reader),
      .cs1       (cs1),
      .fc        (fc),
      .mr        (mr),
      .tc        (tc),
      .er        (er),
      .ds        (ds),
      .dataOut   (dataOut),
      .dataValid (dataValid),
      .attention (attention)
   );

endmodule

//--- sim/mtDriveTb.sv
// Testbench replaying register operations on the drive 0 register set from a data file
module mtDriveTb;
   import mtPkg::*;

   localparam int maxLines    = 128;
   localparam int fieldCount  = 8;
   localparam int resetCycles = 10;

   // Data file op codes
   localparam logic [15:0] opWrite = 16'h1;
   localparam logic [15:0] opRead  = 16'h2;
   localparam logic [15:0] opEnd   = 16'hf;

   logic                   clk;
   logic                   rst;
   logic                   init;
   logic [unitWidth-1:0]   unit;
   logic                   parityTest;
   logic                   write;
   logic                   read;
   logic [regSelWidth-1:0] regSel;
   logic [wordWidth-1:0]   dataIn;
   logic                   mediaOnline;
   logic                   writeLock;
   logic                   drivePresent;
   logic [wordWidth-1:0]   dataOut;
   logic                   dataValid;
   logic                   attention;
   logic                   invertParity;

   logic [15:0] stim [0:maxLines*fieldCount-1];

   // Expectations waiting for their edge
   int          dueQ[$];
   logic        expValidQ[$];
   logic [15:0] expWordQ[$];
   logic [1:0]  expOutQ[$];

   int lineCount;
   int edgeNo     = 0;
   int cycleCount = 0;
   int cycleLimit = 0;

   mtDrive dut_i (
      .clk          (clk),
      .rst          (rst),
      .init         (init),
      .unit         (unit),
      .parityTest   (parityTest),
      .write        (write),
      .read         (read),
      .regSel       (regSel),
      .dataIn       (dataIn),
      .mediaOnline  (mediaOnline),
      .writeLock    (writeLock),
      .drivePresent (drivePresent),
      .dataOut      (dataOut),
      .dataValid    (dataValid),
      .attention    (attention),
      .invertParity (invertParity)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Run limit
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
         $display("timeout after %0d cycles with %0d reads outstanding", cycleCount, dueQ.size());
         $display("Regression failed");
         $fatal(1);
      end
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   task automatic reportMismatch(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
      $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Regression failed");
      $fatal(1);
   endtask

   // Index of the end marker
   function automatic int countLines();
      int n;
      n = -1;
      for (int i = 0; i < maxLines; i++) begin
         if (n < 0 && stim[i*fieldCount] === opEnd) begin
            n = i;
         end
      end
      return n;
   endfunction

   task automatic applyLine(input int idx);
      int          base;
      logic [15:0] op;
      logic [15:0] unitField;
      logic [15:0] flags;
      logic [15:0] levels;
      base      = idx * fieldCount;
      op        = stim[base];
      unitField = stim[base + 1];
      flags     = stim[base + 2];
      levels    = stim[base + 3];
      write        = (op == opWrite);
      read         = (op == opRead);
      unit         = unitField[unitWidth-1:0];
      parityTest   = flags[0];
      init         = flags[1];
      mediaOnline  = levels[2];
      writeLock    = levels[1];
      drivePresent = levels[0];
      regSel       = stim[base + 4][regSelWidth-1:0];
      dataIn       = stim[base + 5];
      // Result two edges on, only drive 0 answers
      dueQ.push_back(edgeNo + 2);
      expValidQ.push_back(read && unitField == 16'h0);
      expWordQ.push_back(stim[base + 6]);
      expOutQ.push_back(stim[base + 7][1:0]);
   endtask

   task automatic checkStep();
      logic        expValid;
      logic [15:0] expWord;
      logic [1:0]  expOut;
      if (dueQ.size() > 0 && dueQ[0] == edgeNo) begin
         void'(dueQ.pop_front());
         expValid = expValidQ.pop_front();
         expWord  = expWordQ.pop_front();
         expOut   = expOutQ.pop_front();
         assert (dataValid === expValid)
            else reportMismatch("dataValid", {15'b0, dataValid}, {15'b0, expValid});
         if (expValid) begin
            assert (dataOut === expWord) else reportMismatch("dataOut", dataOut, expWord);
         end
         assert (attention === expOut[0])
            else reportMismatch("attention", {15'b0, attention}, {15'b0, expOut[0]});
         assert (invertParity === expOut[1])
            else reportMismatch("invertParity", {15'b0, invertParity}, {15'b0, expOut[1]});
      end else begin
         // No read due this cycle
         assert (dataValid === 1'b0)
            else reportMismatch("dataValid", {15'b0, dataValid}, 16'h0);
      end
   endtask

   task automatic advance();
      @(posedge clk);
      edgeNo++;
      #1;
      checkStep();
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      rst          = 1'b1;
      init         = 1'b0;
      unit         = '0;
      parityTest   = 1'b0;
      write        = 1'b0;
      read         = 1'b0;
      regSel       = '0;
      dataIn       = '0;
      mediaOnline  = 1'b0;
      writeLock    = 1'b0;
      drivePresent = 1'b0;
      $readmemh("sim/testdata.hex", stim);
      lineCount = countLines();
      if (lineCount <= 0) begin
         $display("stimulus data holds no operations before its end marker");
         $display("Regression failed");
         $fatal(1);
      end
      cycleLimit = 4 * lineCount + 40;
      repeat (resetCycles) @(posedge clk);
      #1;
      rst = 1'b0;
      // Quiet outputs out of reset
      assert (dataValid === 1'b0) else reportMismatch("dataValid", {15'b0, dataValid}, 16'h0);
      assert (attention === 1'b0) else reportMismatch("attention", {15'b0, attention}, 16'h0);
      assert (invertParity === 1'b0)
         else reportMismatch("invertParity", {15'b0, invertParity}, 16'h0);
      for (int i = 0; i < lineCount; i++) begin
         applyLine(i);
         advance();
      end
      write      = 1'b0;
      read       = 1'b0;
      init       = 1'b0;
      parityTest = 1'b0;
      // Drain outstanding results
      while (dueQ.size() > 0) begin
         advance();
      end
      $display("Regression passed");
      $finish;
   end

endmodule

//--- compile.f
source/mtPkg.sv
source/mtIf.sv
source/mtBusDecoder.sv
source/mtCommandDecoder.sv
source/mtControlRegs.sv
source/mtStatusRegs.sv
source/mtReadPort.sv
source/mtDrive.sv
sim/mtDriveTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the drive register testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mtDriveTb \
   -f compile.f -Mdir obj_dir -o mtDriveSim
if [ $? -ne 0 ]; then
   echo "Verilator build did not complete"
   exit 1
fi

simOutput=$(./obj_dir/mtDriveSim)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1

//--- sim/testdata.hex
// Columns: op unit flags levels regSel data expectedRead expectedOut
// op 0 idle, 1 write, 2 read, f end; flags bit1 init, bit0 parityTest
// levels bit2 mediaOnline, bit1 writeLock, bit0 drivePresent; out bit1 invertParity, bit0 attention
0 0 0 5 00 0000 0000 0
1 0 0 5 05 1234 0000 0
2 0 0 5 05 0000 1234 0
2 0 0 5 09 0000 1000 0
1 0 0 5 03 00a0 0000 0
1 0 0 5 09 0456 0000 0
1 3 0 5 05 beef 0000 0
1 3 0 5 09 ffff 0000 0
2 3 0 5 05 0000 0000 0
2 0 0 5 05 0000 1234 0
2 0 0 5 03 0000 00a0 0
2 0 0 5 09 0000 0456 0
2 0 0 5 06 0000 c42c 0
2 0 0 5 08 0000 0001 0
2 0 0 5 07 0000 0000 0
2 0 0 5 01 0000 1180 0
// Command decoding and attention
1 0 0 5 00 0005 0000 1
2 0 0 5 02 0000 0001 1
2 0 0 5 01 0000 d180 1
2 0 0 5 00 0000 0084 1
1 0 0 5 00 0009 0000 0
2 0 0 5 01 0000 1180 0
1 0 0 5 00 0007 0000 1
2 0 0 5 02 0000 0000 1
2 0 0 5 00 0000 0086 1
2 0 0 5 04 0000 0001 1
1 0 0 5 04 0001 0000 0
2 0 0 5 04 0000 0000 0
// Init and preset
1 0 0 5 00 0005 0000 1
1 0 0 5 09 0333 0000 1
0 0 2 5 00 0000 0000 0
2 0 0 5 02 0000 0000 0
2 0 0 5 09 0000 0000 0
1 0 0 5 09 0333 0000 0
1 0 0 5 00 0011 0000 0
2 0 0 5 09 0000 0000 0
// Parity test
1 0 1 5 03 0042 0000 1
2 0 0 5 03 0000 0042 1
2 0 0 5 02 0000 0008 1
1 0 0 5 00 0009 0000 0
1 0 1 5 00 0007 0000 0
2 0 0 5 00 0000 0088 0
// Maintenance parity and drive levels
1 0 0 5 03 0003 0000 2
2 0 0 2 01 0000 0880 2
1 0 0 2 03 0005 0000 0
2 0 0 7 01 0000 1980 0
f 0 0 0 00 0000 0000 0
